// File: design/rf_fifo_defines.svh
`ifndef RF_FIFO_DEFINES_SVH
`define RF_FIFO_DEFINES_SVH

// ----------------------------------------
// Register file geometry
// ----------------------------------------

// Number of entries in the array
`define RF_DEPTH 8

// Address width follows from the depth
`define RF_ADDR_WIDTH ($clog2(`RF_DEPTH))

// Bits per stored entry
`define RF_WIDTH 17

// ----------------------------------------
// Power gating
// ----------------------------------------

// Edges from power enable low until the array acknowledges
`define RF_WAKE_CYCLES 4

// Empty and input-idle cycles tolerated before the array is switched off
`define RF_IDLE_CYCLES 16

`endif

// File: design/rf_fifo_pkg.sv
`default_nettype none

`include "rf_fifo_defines.svh"

package rf_fifo_pkg;

    // ----------------------------------------
    // Array port requests
    // ----------------------------------------

    // Write port request, stored at the edge where it is presented
    typedef struct packed {
        logic                         we;
        logic [`RF_ADDR_WIDTH-1:0]    addr;
        logic [`RF_WIDTH-1:0]         data;
    } rf_wr_req_t;

    // Read port request, data shows one edge after it is sampled
    typedef struct packed {
        logic                         re;
        logic [`RF_ADDR_WIDTH-1:0]    addr;
    } rf_rd_req_t;

    // ----------------------------------------
    // Power interface
    // ----------------------------------------

    // Power enable is active low and isolation is active high
    typedef struct packed {
        logic                         pwr_enable_b;
        logic                         isol_en;
    } rf_pwr_t;

    // Power sequencing states
    typedef enum logic [1:0] {
        PWR_OFF   = 2'd0,
        PWR_WAKE  = 2'd1,
        PWR_ON    = 2'd2,
        PWR_SLEEP = 2'd3
    } pwr_state_t;

endpackage

`default_nettype wire

// File: design/rf_pg_8x17.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_fifo_defines.svh"

module rf_pg_8x17 (
     input  logic                        clk
    ,input  logic                        rst
    ,input  rf_fifo_pkg::rf_wr_req_t     wr
    ,input  rf_fifo_pkg::rf_rd_req_t     rd
    ,output logic [`RF_WIDTH-1:0]        rd_data

    // Power interface
    ,input  rf_fifo_pkg::rf_pwr_t        pwr
    ,output logic                        pwr_ack_b
);

// ----------------------------------------
// Storage
// ----------------------------------------

// Behavioral model of the gated array
logic [`RF_WIDTH-1:0] mem [`RF_DEPTH];

// Registered read data before the isolation clamp
logic [`RF_WIDTH-1:0] rd_q;

// Delay line that models the power switch ramp
logic [`RF_WAKE_CYCLES-1:0] ack_chain;

// Removing power loses every entry
// Writes land only while the array is powered
always_ff @(posedge clk) begin
    if (pwr.pwr_enable_b) begin
        for (int i = 0; i < `RF_DEPTH; i++) begin
            mem[i] <= '0;
        end
    end else if (wr.we) begin
        mem[wr.addr] <= wr.data;
    end
end

// One register stage on the read port
always_ff @(posedge clk) begin
    if (pwr.pwr_enable_b) begin
        rd_q <= '0;
    end else if (rd.re) begin
        rd_q <= mem[rd.addr];
    end
end

// Clamp the output to zero while the array is isolated
assign rd_data = pwr.isol_en ? '0 : rd_q;

// ----------------------------------------
// Power acknowledge
// ----------------------------------------

// Enable low ripples through the chain one stage per edge
// Enable high refills the whole chain at once
always_ff @(posedge clk) begin
    if (rst) begin
        ack_chain <= '1;
    end else if (pwr.pwr_enable_b) begin
        ack_chain <= '1;
    end else begin
        ack_chain <= {ack_chain[`RF_WAKE_CYCLES-2:0], 1'b0};
    end
end

assign pwr_ack_b = ack_chain[`RF_WAKE_CYCLES-1];

// ----------------------------------------
// Checks
// ----------------------------------------

// The FIFO side must stay quiet unless the power controller has the array up
a_access_powered: assert property (@(posedge clk) disable iff (rst)
    (wr.we || rd.re) |-> (!pwr.pwr_enable_b && !pwr.isol_en))
    else $error("rf_pg_8x17 access while powered down or isolated");

// Addresses must stay inside the array
a_wr_addr_range: assert property (@(posedge clk) disable iff (rst)
    wr.we |-> (wr.addr < `RF_DEPTH))
    else $error("rf_pg_8x17 write address out of range");

a_rd_addr_range: assert property (@(posedge clk) disable iff (rst)
    rd.re |-> (rd.addr < `RF_DEPTH))
    else $error("rf_pg_8x17 read address out of range");

endmodule

`default_nettype wire

// File: design/rf_pwr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_fifo_defines.svh"

module rf_pwr_ctrl (
     input  logic                        clk
    ,input  logic                        rst
    ,input  logic                        wake_req
    ,input  logic                        busy
    ,output rf_fifo_pkg::rf_pwr_t        pwr
    ,input  logic                        pwr_ack_b
    ,output logic                        array_ready
);

// Idle counter spans RF_IDLE_CYCLES values
localparam int IDLE_W = $clog2(`RF_IDLE_CYCLES);

rf_fifo_pkg::pwr_state_t state_q;
rf_fifo_pkg::pwr_state_t state_d;
rf_fifo_pkg::rf_pwr_t    pwr_d;
logic [IDLE_W-1:0]       idle_q;
logic [IDLE_W-1:0]       idle_d;
logic                    idle_done;

// Last idle cycle before the array is put to sleep
assign idle_done = (idle_q == IDLE_W'(`RF_IDLE_CYCLES - 1));

// ----------------------------------------
// Next state
// ----------------------------------------

always_comb begin
    state_d = state_q;
    pwr_d   = pwr;
    idle_d  = '0;
    case (state_q)
        rf_fifo_pkg::PWR_OFF: begin
            // Traffic at the input starts the power switch
            if (wake_req) begin
                state_d            = rf_fifo_pkg::PWR_WAKE;
                pwr_d.pwr_enable_b = 1'b0;
            end
        end
        rf_fifo_pkg::PWR_WAKE: begin
            // Release the clamp only once the array reports power good
            if (!pwr_ack_b) begin
                state_d       = rf_fifo_pkg::PWR_ON;
                pwr_d.isol_en = 1'b0;
            end
        end
        rf_fifo_pkg::PWR_ON: begin
            // Any stored data or a waiting producer keeps the array up
            if (busy || wake_req) begin
                idle_d = '0;
            end else if (idle_done) begin
                state_d       = rf_fifo_pkg::PWR_SLEEP;
                pwr_d.isol_en = 1'b1;
            end else begin
                idle_d = idle_q + 1'b1;
            end
        end
        rf_fifo_pkg::PWR_SLEEP: begin
            // Clamp went up last edge so power can go now
            state_d            = rf_fifo_pkg::PWR_OFF;
            pwr_d.pwr_enable_b = 1'b1;
        end
        default: begin
            state_d            = rf_fifo_pkg::PWR_OFF;
            pwr_d.pwr_enable_b = 1'b1;
            pwr_d.isol_en      = 1'b1;
        end
    endcase
end

// ----------------------------------------
// State registers
// ----------------------------------------

// Out of reset the array is off and clamped
always_ff @(posedge clk) begin
    if (rst) begin
        state_q          <= rf_fifo_pkg::PWR_OFF;
        pwr.pwr_enable_b <= 1'b1;
        pwr.isol_en      <= 1'b1;
        idle_q           <= '0;
    end else begin
        state_q <= state_d;
        pwr     <= pwr_d;
        idle_q  <= idle_d;
    end
end

// The FIFO may use the array only in the fully powered state
assign array_ready = (state_q == rf_fifo_pkg::PWR_ON);

// Power must never be removed from an unclamped array
a_off_after_isol: assert property (@(posedge clk) disable iff (rst)
    $rose(pwr.pwr_enable_b) |-> $past(pwr.isol_en))
    else $error("rf_pwr_ctrl power removed while isolation low");

endmodule

`default_nettype wire

// File: design/rf_fifo_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_fifo_defines.svh"

module rf_fifo_ctrl (
     input  logic                        clk
    ,input  logic                        rst

    // Producer side
    ,input  logic                        in_valid
    ,output logic                        in_ready
    ,input  logic [`RF_WIDTH-1:0]        in_data

    // Consumer side
    ,output logic                        out_valid
    ,input  logic                        out_ready
    ,output logic [`RF_WIDTH-1:0]        out_data

    // Array and power controller
    ,input  logic                        array_ready
    ,output rf_fifo_pkg::rf_wr_req_t     wr
    ,output rf_fifo_pkg::rf_rd_req_t     rd
    ,input  logic [`RF_WIDTH-1:0]        rd_data
    ,output logic                        busy
    ,output logic                        wake_req
);

// Count must reach RF_DEPTH itself
localparam int CNT_W = $clog2(`RF_DEPTH + 1);

logic [`RF_ADDR_WIDTH-1:0] wr_ptr_q;
logic [`RF_ADDR_WIDTH-1:0] rd_ptr_q;
logic [CNT_W-1:0]          count_q;
logic                      in_fire;
logic                      out_fire;
logic                      rd_issue;
logic                      rd_pend_q;
logic [1:0]                buf_cnt_q;
logic [1:0]                buf_used;
logic                      land_idx;
logic [`RF_WIDTH-1:0]      buf_q [2];

// ----------------------------------------
// Handshakes
// ----------------------------------------

// Accept while powered and the array has a free entry
assign in_ready = array_ready && (count_q < CNT_W'(`RF_DEPTH));
assign in_fire  = in_valid && in_ready;

// Head of the output buffer drives the consumer
assign out_valid = (buf_cnt_q != 2'd0);
assign out_data  = buf_q[0];
assign out_fire  = out_valid && out_ready;

// ----------------------------------------
// Array requests
// ----------------------------------------

// Buffer slots still claimed once this cycle's output transfer leaves,
// the word already in flight included
assign buf_used = buf_cnt_q + {1'b0, rd_pend_q} - {1'b0, out_fire};

// Read ahead whenever a slot will be free for the returning word
assign rd_issue = array_ready && (count_q != '0) && (buf_used < 2'd2);

assign wr = rf_fifo_pkg::rf_wr_req_t'{we: in_fire, addr: wr_ptr_q, data: in_data};
assign rd = rf_fifo_pkg::rf_rd_req_t'{re: rd_issue, addr: rd_ptr_q};

// Keep the array powered while anything is held or moving
assign busy     = (count_q != '0) || (buf_cnt_q != 2'd0) || rd_pend_q;
assign wake_req = in_valid;

// ----------------------------------------
// Pointers and counters
// ----------------------------------------

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr_q  <= '0;
        rd_ptr_q  <= '0;
        count_q   <= '0;
        rd_pend_q <= 1'b0;
        buf_cnt_q <= 2'd0;
    end else begin
        // Depth is a power of two so the pointers wrap on their own
        if (in_fire) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (rd_issue) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        count_q   <= count_q + CNT_W'(in_fire) - CNT_W'(rd_issue);
        rd_pend_q <= rd_issue;
        buf_cnt_q <= buf_cnt_q + {1'b0, rd_pend_q} - {1'b0, out_fire};
    end
end

// ----------------------------------------
// Output buffer
// ----------------------------------------

// Returning word goes behind whatever stays after the pop
assign land_idx = buf_cnt_q[0] && !out_fire;

always_ff @(posedge clk) begin
    if (out_fire) begin
        buf_q[0] <= buf_q[1];
    end
    // Later assignment wins when the pop and the landing share slot zero
    if (rd_pend_q) begin
        buf_q[land_idx] <= rd_data;
    end
end

// Input gating must hold the count within the array
a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count_q <= CNT_W'(`RF_DEPTH))
    else $error("rf_fifo_ctrl count above depth");

// A read issued last cycle must find room in the buffer
a_land_room: assert property (@(posedge clk) disable iff (rst)
    rd_pend_q |-> (buf_cnt_q < 2'd2))
    else $error("rf_fifo_ctrl read data landed on a full buffer");

endmodule

`default_nettype wire

// File: design/rf_fifo_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_fifo_defines.svh"

module rf_fifo_top (
     input  logic                        clk
    ,input  logic                        rst

    // Producer side
    ,input  logic                        in_valid
    ,output logic                        in_ready
    ,input  logic [`RF_WIDTH-1:0]        in_data

    // Consumer side
    ,output logic                        out_valid
    ,input  logic                        out_ready
    ,output logic [`RF_WIDTH-1:0]        out_data

    // High while the array is powered and unclamped
    ,output logic                        pwr_on
);

// ----------------------------------------
// Internal nets
// ----------------------------------------

rf_fifo_pkg::rf_wr_req_t wr;
rf_fifo_pkg::rf_rd_req_t rd;
rf_fifo_pkg::rf_pwr_t    pwr;
logic [`RF_WIDTH-1:0]    rd_data;
logic                    pwr_ack_b;
logic                    array_ready;
logic                    busy;
logic                    wake_req;

// Queue control with read-ahead into the output buffer
rf_fifo_ctrl u_ctrl (
     .clk          (clk)
    ,.rst          (rst)
    ,.in_valid     (in_valid)
    ,.in_ready     (in_ready)
    ,.in_data      (in_data)
    ,.out_valid    (out_valid)
    ,.out_ready    (out_ready)
    ,.out_data     (out_data)
    ,.array_ready  (array_ready)
    ,.wr           (wr)
    ,.rd           (rd)
    ,.rd_data      (rd_data)
    ,.busy         (busy)
    ,.wake_req     (wake_req)
);

// Power sequencing for the array
rf_pwr_ctrl u_pwr (
     .clk          (clk)
    ,.rst          (rst)
    ,.wake_req     (wake_req)
    ,.busy         (busy)
    ,.pwr          (pwr)
    ,.pwr_ack_b    (pwr_ack_b)
    ,.array_ready  (array_ready)
);

// Gated storage
rf_pg_8x17 u_rf (
     .clk          (clk)
    ,.rst          (rst)
    ,.wr           (wr)
    ,.rd           (rd)
    ,.rd_data      (rd_data)
    ,.pwr          (pwr)
    ,.pwr_ack_b    (pwr_ack_b)
);

assign pwr_on = array_ready;

endmodule

`default_nettype wire

// File: dv/rf_fifo_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_fifo_defines.svh"

module rf_fifo_tb;

localparam int CLK_PERIOD  = 40;
localparam int DRIVE_DELAY = 5;
localparam int RST_CYCLES  = 8;
localparam int FULL_LEVEL  = `RF_DEPTH + 2;
localparam int WAKE_LIMIT  = `RF_WAKE_CYCLES + 3;
localparam int IDLE_LIMIT  = `RF_IDLE_CYCLES + 3;

// Cycle budgets for each test, summed into the watchdog time
localparam int DRAIN_CYCLES = 40;
localparam int T1_CYCLES    = 12;
localparam int T2_CYCLES    = WAKE_LIMIT + 2 + DRAIN_CYCLES;
localparam int T3_CYCLES    = 1200 + DRAIN_CYCLES;
localparam int T4_CYCLES    = 40 + 12 + DRAIN_CYCLES;
localparam int T5_CYCLES    = IDLE_LIMIT + 2 + 600 + DRAIN_CYCLES;
localparam int RUN_CYCLES   = RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                              + T4_CYCLES + T5_CYCLES;
localparam int WATCHDOG_NS  = (RUN_CYCLES + 200) * CLK_PERIOD;

logic                 clk;
logic                 rst;
logic                 in_valid;
logic                 in_ready;
logic [`RF_WIDTH-1:0] in_data;
logic                 out_valid;
logic                 out_ready;
logic [`RF_WIDTH-1:0] out_data;
logic                 pwr_on;

// Reference queue and the values it predicts for the coming edge
logic [`RF_WIDTH-1:0] model [$];
logic [`RF_WIDTH-1:0] exp_head;
logic                 exp_empty;
int                   held_cnt;
logic                 in_xfer;
logic                 out_xfer;
logic                 seen_valid;
logic [31:0]          lfsr_state;
int                   error_count;
int                   test_count;
int                   test_err_base;
int                   items_checked;

rf_fifo_top uut (
     .clk       (clk)
    ,.rst       (rst)
    ,.in_valid  (in_valid)
    ,.in_ready  (in_ready)
    ,.in_data   (in_data)
    ,.out_valid (out_valid)
    ,.out_ready (out_ready)
    ,.out_data  (out_data)
    ,.pwr_on    (pwr_on)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// ----------------------------------------
// Helpers
// ----------------------------------------

// Taps 32, 22, 2 and 1 give a maximal length sequence
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value      = {value[30:0], lfsr_state[0]};
    end
endtask

task automatic report_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    error_count++;
endtask

task automatic report_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    error_count++;
endtask

task automatic finish_test(input string name);
    test_count++;
    if (error_count == test_err_base) begin
        $display("test %0d %s: pass", test_count, name);
    end else begin
        $display("test %0d %s: %0d errors", test_count, name, error_count - test_err_base);
    end
    test_err_base = error_count;
endtask

// Half a period after the edge the inputs are settled, so the values seen
// here are the ones the DUT samples on the next rising edge
always @(negedge clk) begin
    if (rst) begin
        model.delete();
        exp_empty  = 1'b1;
        exp_head   = '0;
        held_cnt   = 0;
        in_xfer    = 1'b0;
        out_xfer   = 1'b0;
        seen_valid = 1'b0;
    end else begin
        exp_empty = (model.size() == 0);
        exp_head  = exp_empty ? '0 : model[0];
        held_cnt  = model.size();
        in_xfer   = in_valid && in_ready;
        out_xfer  = out_valid && out_ready;
        if (in_valid) begin
            seen_valid = 1'b1;
        end
        // Pop before push so an item never leaves on the edge it arrives
        if (out_xfer && !exp_empty) begin
            void'(model.pop_front());
            items_checked++;
        end
        if (in_xfer) begin
            model.push_back(in_data);
        end
    end
end

// Wait until the reference queue is empty, with nothing offered
task automatic wait_drain(input int max_cycles);
    logic done;
    done      = 1'b0;
    out_ready = 1'b1;
    for (int c = 0; c < max_cycles && !done; c++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        done = (model.size() == 0);
    end
    if (!done) begin
        report_failure("queue did not drain, items are missing at the output");
    end
endtask

// Random valid and ready until n items are accepted
task automatic run_traffic(input int n_items, input int max_cycles);
    int          sent;
    logic [31:0] r;
    sent = 0;
    for (int c = 0; c < max_cycles && sent < n_items; c++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        if (in_xfer) begin
            sent++;
        end
        // A pending item is held until it transfers
        if (!in_valid || in_xfer) begin
            draw_bits(1, r);
            in_valid = r[0] && (sent < n_items);
            draw_bits(`RF_WIDTH, r);
            in_data = r[`RF_WIDTH-1:0];
        end
        draw_bits(2, r);
        out_ready = |r[1:0];
    end
    if (sent < n_items) begin
        report_failure("random traffic stalled before all items were accepted");
    end
    in_valid = 1'b0;
endtask

// ----------------------------------------
// Checks
// ----------------------------------------

// Quiet outputs between reset and the first in_valid
a_quiet_in_ready: assert property (@(posedge clk) disable iff (rst)
    !seen_valid |-> !in_ready)
    else report_mismatch("in_ready", 0, $sampled(in_ready));
a_quiet_out_valid: assert property (@(posedge clk) disable iff (rst)
    !seen_valid |-> !out_valid)
    else report_mismatch("out_valid", 0, $sampled(out_valid));
a_quiet_pwr_on: assert property (@(posedge clk) disable iff (rst)
    !seen_valid |-> !pwr_on)
    else report_mismatch("pwr_on", 0, $sampled(pwr_on));

// The array accepts nothing while unpowered
a_ready_needs_pwr: assert property (@(posedge clk) disable iff (rst)
    in_ready |-> pwr_on)
    else report_failure("in_ready high while pwr_on is low");

a_wake_bound: assert property (@(posedge clk) disable iff (rst)
    ($rose(in_valid) && !pwr_on) |-> ##[0:WAKE_LIMIT] in_ready)
    else report_failure("in_ready did not rise within the wake time");

// Every output must be the oldest item still held
a_no_extra: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !exp_empty)
    else report_failure("out_valid high with no item left to deliver");
a_order: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !exp_empty) |-> (out_data == exp_head))
    else report_mismatch("out_data", exp_head, $sampled(out_data));

// Powered and not ready happens only with array and buffer both full
a_full_level: assert property (@(posedge clk) disable iff (rst)
    (pwr_on && !in_ready) |-> (held_cnt == FULL_LEVEL))
    else report_mismatch("held items", FULL_LEVEL, held_cnt);
a_cap_max: assert property (@(posedge clk) disable iff (rst)
    held_cnt <= FULL_LEVEL)
    else report_mismatch("held items", FULL_LEVEL, held_cnt);

a_sleep_bound: assert property (@(posedge clk) disable iff (rst)
    (held_cnt == 0 && !in_valid) [*IDLE_LIMIT] |-> !pwr_on)
    else report_mismatch("pwr_on", 0, $sampled(pwr_on));

// ----------------------------------------
// Watchdog
// ----------------------------------------

initial begin
    #WATCHDOG_NS;
    $display("Watchdog expired before the tests completed");
    $display("Something failed");
    $finish;
end

// ----------------------------------------
// Test sequence
// ----------------------------------------

initial begin
    int          accepted;
    int          stalls;
    logic        got;
    logic [31:0] r;
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_data       = '0;
    out_ready     = 1'b0;
    lfsr_state    = 32'h47236dd9;
    error_count   = 0;
    test_count    = 0;
    test_err_base = 0;
    items_checked = 0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // Idle after reset with nothing offered
    repeat (T1_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    finish_test("reset_idle");

    // Single item wakes the array
    draw_bits(`RF_WIDTH, r);
    in_data  = r[`RF_WIDTH-1:0];
    in_valid = 1'b1;
    got      = 1'b0;
    for (int c = 0; c < WAKE_LIMIT + 2 && !got; c++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        got = in_xfer;
    end
    in_valid = 1'b0;
    if (!got) begin
        report_failure("first item was not accepted after wake");
    end
    wait_drain(DRAIN_CYCLES);
    finish_test("wake");

    run_traffic(200, 1200);
    wait_drain(DRAIN_CYCLES);
    finish_test("random_order");

    // Fill against a stalled consumer until in_ready stays low
    out_ready = 1'b0;
    accepted  = 0;
    stalls    = 0;
    draw_bits(`RF_WIDTH, r);
    in_data  = r[`RF_WIDTH-1:0];
    in_valid = 1'b1;
    for (int c = 0; c < 40 && stalls < 4; c++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        if (in_xfer) begin
            accepted++;
            draw_bits(`RF_WIDTH, r);
            in_data = r[`RF_WIDTH-1:0];
        end
        stalls = (pwr_on && !in_ready) ? stalls + 1 : 0;
    end
    assert (accepted == FULL_LEVEL)
        else report_mismatch("accepted items", FULL_LEVEL, accepted);
    // The held item goes in once the consumer frees space
    out_ready = 1'b1;
    got       = 1'b0;
    for (int c = 0; c < 12 && !got; c++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        got = in_xfer;
    end
    in_valid = 1'b0;
    wait_drain(DRAIN_CYCLES);
    finish_test("capacity");

    // Empty and quiet through the whole sleep window
    got = 1'b0;
    for (int c = 0; c < IDLE_LIMIT + 2; c++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        if (!pwr_on) begin
            got = 1'b1;
        end
    end
    if (!got) begin
        report_failure("array stayed powered while the queue was idle");
    end
    $display("power state after idle: %s", uut.u_pwr.state_q.name());
    run_traffic(100, 600);
    wait_drain(DRAIN_CYCLES);
    finish_test("sleep_rewake");

    $display("%0d tests run, %0d items checked, %0d errors",
             test_count, items_checked, error_count);
    if (error_count == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/rf_fifo_pkg.sv
design/rf_pg_8x17.sv
design/rf_pwr_ctrl.sv
design/rf_fifo_ctrl.sv
design/rf_fifo_top.sv
dv/rf_fifo_tb.sv

// File: Bender.yml
package:
  name: rf_fifo

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rf_fifo_pkg.sv
      - design/rf_pg_8x17.sv
      - design/rf_pwr_ctrl.sv
      - design/rf_fifo_ctrl.sv
      - design/rf_fifo_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/rf_fifo_tb.sv
